// File: flist.f
+incdir+bench
source/valu_pkg.sv
source/valu_decode.sv
source/valu_arith.sv
source/valu_exec.sv
source/valu_resp.sv
source/valu_top.sv
bench/valu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the valu lane testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module valu_tb -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
out=$(./obj_dir/Vvalu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi
if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: bench/valu_model.svh
`ifndef valu_model_svh
`define valu_model_svh

function automatic logic fn_known(func_id_t fn);
    return fn inside {fn_add, fn_sub, fn_rsub, fn_minu, fn_min, fn_maxu, fn_max,
                      fn_and, fn_or, fn_xor, fn_move};
endfunction

// works the expected response one element at a time at width 8 << sew
function automatic valu_resp_t model_resp(valu_req_t r);
    valu_resp_t m;
    int w;
    vdata_t mask;
    vdata_t sbit;
    vdata_t ea;
    vdata_t eb;
    vdata_t er;
    w = 8 << r.sew;
    mask = (w == data_w) ? '1 : ((vdata_t'(1) << w) - vdata_t'(1));
    sbit = vdata_t'(1) << (w - 1);
    m.data = '0;
    m.tag = r.tag;
    for (int i = 0; i < data_w / w; i++) begin
        ea = (r.data0 >> (i * w)) & mask;
        eb = (r.data1 >> (i * w)) & mask;
        case (r.func_id)
            fn_add: er = ea + eb;
            fn_sub: er = ea - eb;
            fn_rsub: er = eb - ea;
            fn_minu: er = (ea < eb) ? ea : eb;
            fn_maxu: er = (ea < eb) ? eb : ea;
            fn_min: er = ((ea ^ sbit) < (eb ^ sbit)) ? ea : eb;   // offset binary compare.
            fn_max: er = ((ea ^ sbit) < (eb ^ sbit)) ? eb : ea;
            fn_and: er = ea & eb;
            fn_or: er = ea | eb;
            fn_xor: er = ea ^ eb;
            fn_move: er = ea;
            default: er = '0;
        endcase
        m.data = m.data | ((er & mask) << (i * w));   // wrap stays inside the element.
    end
    if (!fn_known(r.func_id)) begin
        m.tag.be = '0;
    end
    return m;
endfunction

`endif

// File: bench/valu_tb.sv
`timescale 1ns/1ps

module valu_tb
    import valu_pkg::*;
();

    localparam int clk_period = 8;
    localparam int reset_cycles = 16;
    localparam int n_random = 300;
    localparam int slack = 10;

    localparam int t_arith = 0;
    localparam int t_minmax = 1;
    localparam int t_logic = 2;
    localparam int t_unsup = 3;
    localparam int t_random = 4;
    localparam int t_reset = 5;

    localparam func_id_t arith_fns [3] = '{fn_add, fn_sub, fn_rsub};
    localparam func_id_t minmax_fns [4] = '{fn_minu, fn_min, fn_maxu, fn_max};
    localparam func_id_t logic_fns [4] = '{fn_and, fn_or, fn_xor, fn_move};
    localparam func_id_t rand_fns [13] = '{fn_add, fn_sub, fn_rsub, fn_minu, fn_min,
        fn_maxu, fn_max, fn_and, fn_or, fn_xor, fn_move, 6'b001000, 6'b100000};

    `include "valu_model.svh"

    logic clk = 1'b0;
    logic rst = 1'b1;
    valu_req_t req = '0;
    logic req_valid = 1'b0;
    logic req_ready;
    valu_resp_t resp;
    logic resp_valid;
    logic resp_ready = 1'b1;

    logic [31:0] rng_state = 32'd77;
    logic random_mode = 1'b0;
    int cycle = 0;
    int cur_test = 0;
    int n_total = 0;

    valu_req_t stim_q[$];
    int stim_test_q[$];
    valu_resp_t exp_q[$];   // scoreboard with the oldest entry first.
    int exp_test_q[$];
    int acc_q[$];

    valu_resp_t head_resp = '0;
    int head_test = 0;
    int head_acc = 0;
    int head_count = 0;

    valu_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic vdata_t rand64();
        return {next_rand(), next_rand()};
    endfunction

    // a one in the low bit of every element
    function automatic vdata_t elem_ones(sew_t s);
        case (s)
            sew_8: return 64'h0101010101010101;
            sew_16: return 64'h0001000100010001;
            sew_32: return 64'h0000000100000001;
            default: return 64'h0000000000000001;
        endcase
    endfunction

    function automatic string test_label(int t);
        case (t)
            t_arith: return "add_sub_rsub";
            t_minmax: return "min_max";
            t_logic: return "logic_move";
            t_unsup: return "unsupported";
            t_random: return "random_stall";
            default: return "reset";
        endcase
    endfunction

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic value_error(int test, string what, logic [127:0] expected,
                               logic [127:0] actual);
        $display("error: test %s %s expected %h actual %h", test_label(test), what,
                 expected, actual);
        stop_failed();
    endtask

    task automatic plain_error(string what);
        $display("%s", what);
        stop_failed();
    endtask

    task automatic add_req(int test, func_id_t fn, sew_t sew, vdata_t d0, vdata_t d1);
        valu_req_t r;
        r.func_id = fn;
        r.sew = sew;
        r.data0 = d0;
        r.data1 = d1;
        r.tag.addr = next_rand();
        r.tag.be = vbe_t'(next_rand());
        stim_q.push_back(r);
        stim_test_q.push_back(test);
    endtask

    task automatic wait_drained();
        while (stim_q.size() != 0 || exp_q.size() != 0 || req_valid) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            resp_ready <= 1'b1;
        end else begin
            cycle <= cycle + 1;
            if (resp_valid && resp_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
                void'(exp_test_q.pop_front());
                void'(acc_q.pop_front());
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(model_resp(req));
                exp_test_q.push_back(cur_test);
                acc_q.push_back(cycle);
            end
            if (!req_valid || req_ready) begin   // held until taken.
                if (stim_q.size() != 0 && (!random_mode || next_rand() % 4 != 0)) begin
                    req <= stim_q.pop_front();
                    cur_test <= stim_test_q.pop_front();
                    req_valid <= 1'b1;
                end else begin
                    req_valid <= 1'b0;
                end
            end
            resp_ready <= !random_mode || (next_rand() % 3 != 0);
            head_count <= exp_q.size();
            if (exp_q.size() != 0) begin
                head_resp <= exp_q[0];
                head_test <= exp_test_q[0];
                head_acc <= acc_q[0];
            end
        end
    end

    initial begin
        vdata_t ones;
        vdata_t signs;
        int k;
        for (int s = 0; s < 4; s++) begin
            ones = elem_ones(sew_t'(s));
            signs = ones << ((8 << s) - 1);
            for (int f = 0; f < 3; f++) begin
                add_req(t_arith, arith_fns[f], sew_t'(s), '1, ones);
                add_req(t_arith, arith_fns[f], sew_t'(s), '0, ones);
                add_req(t_arith, arith_fns[f], sew_t'(s), ~signs, ones);
                add_req(t_arith, arith_fns[f], sew_t'(s), rand64(), rand64());
            end
            for (int f = 0; f < 4; f++) begin
                add_req(t_minmax, minmax_fns[f], sew_t'(s), 64'hf0e1d2c3b4a59687,
                        64'h0f1e2d3c4b5a6978);
                add_req(t_minmax, minmax_fns[f], sew_t'(s), signs, ~signs);
                add_req(t_minmax, minmax_fns[f], sew_t'(s), rand64(), rand64());
            end
            add_req(t_logic, logic_fns[s], sew_t'(s), rand64(), rand64());
        end
        add_req(t_unsup, 6'b000001, sew_8, rand64(), rand64());
        add_req(t_unsup, 6'b111111, sew_64, rand64(), rand64());
        add_req(t_unsup, 6'b010110, sew_32, rand64(), rand64());
        n_total = stim_q.size() + n_random;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!resp_valid && req_ready)
            else value_error(t_reset, "resp_valid req_ready", 128'(2'b01),
                             128'({resp_valid, req_ready}));
        wait_drained();
        for (int n = 0; n < n_random; n++) begin
            k = int'(next_rand() % 13);
            add_req(t_random, rand_fns[k], sew_t'(next_rand()), rand64(), rand64());
        end
        random_mode = 1'b1;
        wait_drained();
        repeat (2 * pipe_latency) @(negedge clk);
        if (resp_valid) begin
            plain_error("extra response after every request was answered");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    initial begin
        wait (n_total != 0);
        #(n_total * slack * clk_period);
        plain_error("watchdog timeout with responses still outstanding");
    end

    a_resp_expected: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid && resp_ready |-> head_count != 0
    ) else plain_error("response arrived with no request outstanding");

    a_resp_value: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid && resp_ready && head_count != 0 |-> resp == head_resp
    ) else value_error($sampled(head_test), "response", 128'($sampled(head_resp)),
                       128'($sampled(resp)));

    // only while resp_ready is held high
    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid && resp_ready && head_count != 0 && head_test != t_random
            |-> cycle - head_acc == pipe_latency
    ) else value_error($sampled(head_test), "latency", 128'(pipe_latency),
                       128'($sampled(cycle) - $sampled(head_acc)));

    a_resp_stall: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp)
    ) else plain_error("response changed or dropped while stalled");

endmodule

// File: source/valu_top.sv
`timescale 1ns/1ps

module valu_top
    import valu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  valu_req_t  req,
    input  logic       req_valid,
    output logic       req_ready,
    output valu_resp_t resp,
    output logic       resp_valid,
    input  logic       resp_ready
);

    valu_op_t op;
    logic op_valid;
    valu_resp_t res;
    logic res_valid;
    logic advance;

    // whole pipeline moves together.
    assign req_ready = advance;

    valu_decode decode0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .advance   (advance),
        .op        (op),
        .op_valid  (op_valid)
    );

    valu_exec exec0 (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_valid  (op_valid),
        .advance   (advance),
        .res       (res),
        .res_valid (res_valid)
    );

    valu_resp resp0 (
        .clk        (clk),
        .rst        (rst),
        .res        (res),
        .res_valid  (res_valid),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .advance    (advance)
    );

endmodule

// File: source/valu_resp.sv
`timescale 1ns/1ps

module valu_resp
    import valu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  valu_resp_t res,
    input  logic       res_valid,
    output valu_resp_t resp,
    output logic       resp_valid,
    input  logic       resp_ready,
    output logic       advance
);

    typedef enum logic {skid_empty, skid_full} skid_state_e;

    skid_state_e state_q;
    valu_resp_t skid_q;
    logic out_stall;

    assign out_stall = resp_valid && !resp_ready;
    assign advance   = (state_q == skid_empty);   // driven by state_q alone.

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= skid_empty;
            resp_valid <= 1'b0;
        end else if (state_q == skid_empty) begin
            if (!out_stall) begin
                resp_valid <= res_valid;
            end else if (res_valid) begin
                state_q <= skid_full;
            end
        end else if (resp_ready) begin
            state_q <= skid_empty;   // skid moves to output.
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == skid_empty) begin
            if (!out_stall && res_valid) begin
                resp <= res;
            end else if (out_stall && res_valid) begin
                skid_q <= res;
            end
        end else if (resp_ready) begin
            resp <= skid_q;
        end
    end

    a_resp_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_stall |=> resp_valid && $stable(resp)
    );

    // with the skid full the execute stage must hold its item
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == skid_full) && res_valid |=> res_valid && $stable(res)
    );

endmodule

// File: source/valu_exec.sv
`timescale 1ns/1ps

module valu_exec
    import valu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  valu_op_t   op,
    input  logic       op_valid,
    input  logic       advance,
    output valu_resp_t res,
    output logic       res_valid
);

    vdata_t sum;
    vdata_t minmax;
    valu_resp_t nxt;

    valu_arith arith0 (
        .a      (op.data0),
        .b      (op.data1),
        .sew    (op.sew),
        .op     (op.op),
        .sum    (sum),
        .minmax (minmax)
    );

    always_comb begin
        nxt.tag = op.tag;
        case (op.op)
            op_add, op_sub, op_rsub: nxt.data = sum;
            op_minu, op_min, op_maxu, op_max: nxt.data = minmax;
            op_and: nxt.data = op.data0 & op.data1;
            op_or: nxt.data = op.data0 | op.data1;
            op_xor: nxt.data = op.data0 ^ op.data1;
            op_move: nxt.data = op.data0;
            default: begin
                nxt.data   = '0;
                nxt.tag.be = '0;   // unsupported code writes nothing.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (advance) begin
            res_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            res <= nxt;
        end
    end

endmodule

// File: source/valu_arith.sv
`timescale 1ns/1ps

module valu_arith
    import valu_pkg::*;
(
    input  vdata_t  a,
    input  vdata_t  b,
    input  sew_t    sew,
    input  alu_op_e op,
    output vdata_t  sum,
    output vdata_t  minmax
);

    vdata_t x;
    vdata_t y;
    logic cin0;
    logic [be_w-1:0] border;
    logic [be_w-1:0] cout;
    logic [2:0] top_mask;
    logic is_min;
    logic is_signed;

    // subtraction is x + ~y + 1.
    always_comb begin
        case (op)
            op_sub, op_minu, op_min, op_maxu, op_max: begin
                x    = a;
                y    = ~b;
                cin0 = 1'b1;
            end
            op_rsub: begin
                x    = b;
                y    = ~a;
                cin0 = 1'b1;
            end
            default: begin
                x    = a;
                y    = b;
                cin0 = 1'b0;
            end
        endcase
    end

    // first byte of each element and offset to its top byte
    always_comb begin
        case (sew)
            sew_8: begin
                border   = 8'hff;
                top_mask = 3'd0;
            end
            sew_16: begin
                border   = 8'h55;
                top_mask = 3'd1;
            end
            sew_32: begin
                border   = 8'h11;
                top_mask = 3'd3;
            end
            default: begin
                border   = 8'h01;
                top_mask = 3'd7;
            end
        endcase
    end

    always_comb begin
        logic carry;
        logic [8:0] slice;
        carry = 1'b0;
        for (int i = 0; i < be_w; i++) begin
            if (border[i]) begin
                carry = cin0;   // chain restarts per element.
            end
            slice = {1'b0, x[8*i +: 8]} + {1'b0, y[8*i +: 8]} + {8'd0, carry};
            sum[8*i +: 8] = slice[7:0];
            cout[i] = slice[8];
            carry = slice[8];
        end
    end

    assign is_min    = (op == op_min) || (op == op_minu);
    assign is_signed = (op == op_min) || (op == op_max);

    // a < b read off the top byte of each element of a - b
    always_comb begin
        logic [2:0] top;
        logic sign_a;
        logic sign_b;
        logic lt_u;
        logic lt;
        for (int i = 0; i < be_w; i++) begin
            top    = 3'(i) | top_mask;
            sign_a = a[8*top + 7];
            sign_b = b[8*top + 7];
            lt_u   = ~cout[top];   // borrow out.
            if (is_signed && (sign_a != sign_b)) begin
                lt = sign_a;
            end else begin
                lt = lt_u;
            end
            if (is_min == lt) begin
                minmax[8*i +: 8] = a[8*i +: 8];
            end else begin
                minmax[8*i +: 8] = b[8*i +: 8];
            end
        end
    end

endmodule

// File: source/valu_decode.sv
`timescale 1ns/1ps

module valu_decode
    import valu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  valu_req_t req,
    input  logic      req_valid,
    input  logic      advance,
    output valu_op_t  op,
    output logic      op_valid
);

    alu_op_e dec_op;

    always_comb begin
        case (req.func_id)
            fn_add: begin
                dec_op = op_add;
            end
            fn_sub: begin
                dec_op = op_sub;
            end
            fn_rsub: begin
                dec_op = op_rsub;
            end
            fn_minu: begin
                dec_op = op_minu;
            end
            fn_min: begin
                dec_op = op_min;
            end
            fn_maxu: begin
                dec_op = op_maxu;
            end
            fn_max: begin
                dec_op = op_max;
            end
            fn_and: begin
                dec_op = op_and;
            end
            fn_or: begin
                dec_op = op_or;
            end
            fn_xor: begin
                dec_op = op_xor;
            end
            fn_move: begin
                dec_op = op_move;
            end
            default: begin
                dec_op = op_none;   // answered, but writes nothing.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (advance) begin
            op_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op.op    <= dec_op;
            op.sew   <= req.sew;
            op.data0 <= req.data0;
            op.data1 <= req.data1;
            op.tag   <= req.tag;
        end
    end

    // source must hold a request that was not taken.
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        req_valid && !advance |=> $stable(req)
    );

endmodule

// File: source/valu_pkg.sv
package valu_pkg;

    localparam int data_w = 64;
    localparam int addr_w = 32;
    localparam int be_w = data_w / 8;
    localparam int func_w = 6;

    // cycles from request accept to response handshake
    localparam int pipe_latency = 3;

    typedef logic [data_w-1:0] vdata_t;
    typedef logic [addr_w-1:0] vaddr_t;
    typedef logic [be_w-1:0]   vbe_t;
    typedef logic [func_w-1:0] func_id_t;
    typedef logic [1:0]        sew_t;

    localparam sew_t sew_8  = 2'd0;
    localparam sew_t sew_16 = 2'd1;
    localparam sew_t sew_32 = 2'd2;
    localparam sew_t sew_64 = 2'd3;

    localparam func_id_t fn_add  = 6'b000000;
    localparam func_id_t fn_sub  = 6'b000010;
    localparam func_id_t fn_rsub = 6'b000011;
    localparam func_id_t fn_minu = 6'b000100;
    localparam func_id_t fn_min  = 6'b000101;
    localparam func_id_t fn_maxu = 6'b000110;
    localparam func_id_t fn_max  = 6'b000111;
    localparam func_id_t fn_and  = 6'b001001;
    localparam func_id_t fn_or   = 6'b001010;
    localparam func_id_t fn_xor  = 6'b001011;
    localparam func_id_t fn_move = 6'b010111;

    typedef enum logic [3:0] {
        op_none,
        op_add,
        op_sub,
        op_rsub,
        op_minu,
        op_min,
        op_maxu,
        op_max,
        op_and,
        op_or,
        op_xor,
        op_move
    } alu_op_e;

    typedef struct packed {
        vaddr_t addr;
        vbe_t   be;
    } valu_tag_t;

    typedef struct packed {
        func_id_t  func_id;
        sew_t      sew;
        vdata_t    data0;
        vdata_t    data1;
        valu_tag_t tag;
    } valu_req_t;

    typedef struct packed {
        alu_op_e   op;
        sew_t      sew;
        vdata_t    data0;
        vdata_t    data1;
        valu_tag_t tag;
    } valu_op_t;

    typedef struct packed {
        vdata_t    data;
        valu_tag_t tag;
    } valu_resp_t;

endpackage
